/* src/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    ////////////////////
    // cache geometry
    ////////////////////

    localparam int DC_WORD_W     = 32;  // cpu data word
    localparam int DC_ADDR_W     = 32;  // cpu byte address
    localparam int DC_LINE_WORDS = 4;
    localparam int DC_OFFSET_W   = 2;   // word within a line

    // two ways only, the lru is a single bit per set
    localparam int DC_WAYS = 2;

    localparam int DC_BYTE_OFF_W  = $clog2(DC_WORD_W / 8);
    localparam int DC_LINE_W      = DC_WORD_W * DC_LINE_WORDS;
    localparam int DC_LINE_ADDR_W = DC_ADDR_W - DC_OFFSET_W - DC_BYTE_OFF_W; // 28 bits

    ////////////////////
    // line layout
    ////////////////////

    // flat on the memory port and in the data arrays,
    // word by word for offset select and write-hit merge
    typedef union packed {
        logic [DC_LINE_W-1:0]                    flat;
        logic [DC_LINE_WORDS-1:0][DC_WORD_W-1:0] words;
    } dc_line_u;

endpackage

`default_nettype wire

/* src/dcache_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

// request held in the lookup register, seen by compare stage and miss controller
interface dcache_req_if;

    logic                             valid;  // live request in lookup register
    logic                             we;
    logic [dcache_pkg::DC_ADDR_W-1:0] addr;
    logic [dcache_pkg::DC_WORD_W-1:0] wdata;

    modport src (
        output valid,
        output we,
        output addr,
        output wdata
    );

    modport dst (
        input valid,
        input we,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

/* src/dcache_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_lookup #(
    parameter  int NUM_SETS = 16,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = dcache_pkg::DC_LINE_ADDR_W - IDX_W
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    // cpu request
    input  logic                                           req,
    input  logic                                           we,
    input  logic [dcache_pkg::DC_ADDR_W-1:0]               addr,
    input  logic [dcache_pkg::DC_WORD_W-1:0]               wdata,
    output logic                                           ready,
    input  logic                                           hold,
    // write-hit commit
    input  logic                                           hit_we,
    input  logic                                           hit_way,
    input  dcache_pkg::dc_line_u                           hit_line,
    // refill
    input  logic                                           fill_we,
    input  logic                                           fill_way,
    input  dcache_pkg::dc_line_u                           fill_line,
    input  logic [TAG_W-1:0]                               fill_tag,
    dcache_req_if.src                                      rq,
    // array read of the registered index
    output logic [dcache_pkg::DC_WAYS-1:0][TAG_W-1:0]      tags,
    output logic [dcache_pkg::DC_WAYS-1:0]                 valids,
    output logic [dcache_pkg::DC_WAYS-1:0]                 dirties,
    output logic                                           lru,
    output dcache_pkg::dc_line_u [dcache_pkg::DC_WAYS-1:0] lines
);

    logic [IDX_W-1:0]                               idx;
    logic [NUM_SETS-1:0][dcache_pkg::DC_WAYS-1:0]   valid_q;
    logic [NUM_SETS-1:0][dcache_pkg::DC_WAYS-1:0]   dirty_q;
    logic [NUM_SETS-1:0]                            lru_q;   // way to evict next
    logic [TAG_W-1:0]             tag_mem  [NUM_SETS][dcache_pkg::DC_WAYS];
    logic [dcache_pkg::DC_LINE_W-1:0] data_mem [dcache_pkg::DC_WAYS][NUM_SETS];

    ////////////////////
    // request register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rq.valid <= 1'b0;
        end else if (!hold) begin
            rq.valid <= req;  // frees the slot once compare takes it
        end
    end

    always_ff @(posedge clk) begin
        if (req && !hold) begin
            rq.we    <= we;
            rq.addr  <= addr;
            rq.wdata <= wdata;
        end
    end

    // a write blocks one cycle so its commit lands before the next lookup
    assign ready = !hold && !(rq.valid && rq.we);

    assign idx = rq.addr[dcache_pkg::DC_BYTE_OFF_W + dcache_pkg::DC_OFFSET_W +: IDX_W];

    ////////////////////
    // arrays
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (fill_we) begin
            valid_q[idx][fill_way] <= 1'b1;
            dirty_q[idx][fill_way] <= 1'b0;  // refilled line is clean
            lru_q[idx]             <= !fill_way;
        end else if (hit_we) begin
            dirty_q[idx][hit_way] <= 1'b1;
            lru_q[idx]            <= !hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[idx][fill_way]  <= fill_tag;
            data_mem[fill_way][idx] <= fill_line.flat;
        end else if (hit_we) begin
            data_mem[hit_way][idx] <= hit_line.flat;
        end
    end

    // asynchronous read
    always_comb begin
        for (int w = 0; w < dcache_pkg::DC_WAYS; w++) begin
            tags[w]       = tag_mem[idx][w];
            lines[w].flat = data_mem[w][idx];
        end
    end

    assign valids  = valid_q[idx];
    assign dirties = dirty_q[idx];
    assign lru     = lru_q[idx];

    a_req_only_when_ready: assert property (
        @(posedge clk) disable iff (!rst_n) req |-> ready
    );

endmodule

`default_nettype wire

/* src/dcache_hit_check.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_hit_check #(
    parameter  int NUM_SETS = 16,
    localparam int TAG_W    = dcache_pkg::DC_LINE_ADDR_W - $clog2(NUM_SETS)
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    dcache_req_if.dst                                      rq,
    input  logic [dcache_pkg::DC_WAYS-1:0][TAG_W-1:0]      tags,
    input  logic [dcache_pkg::DC_WAYS-1:0]                 valids,
    input  logic                                           lru,
    input  dcache_pkg::dc_line_u [dcache_pkg::DC_WAYS-1:0] lines,
    output logic                                           hit_we,
    output logic                                           hit_way,
    output dcache_pkg::dc_line_u                           hit_line,
    output logic                                           miss,
    output logic                                           victim_way,
    output logic                                           resp_valid,
    output logic [dcache_pkg::DC_WORD_W-1:0]               rdata
);

    logic [TAG_W-1:0]                  req_tag;
    logic [dcache_pkg::DC_OFFSET_W-1:0] off;
    logic [dcache_pkg::DC_WAYS-1:0]    way_hit;
    logic                              hit;
    dcache_pkg::dc_line_u              sel_line;

    assign req_tag = rq.addr[dcache_pkg::DC_ADDR_W-1 -: TAG_W];
    assign off     = rq.addr[dcache_pkg::DC_BYTE_OFF_W +: dcache_pkg::DC_OFFSET_W];

    ////////////////////
    // tag compare
    ////////////////////

    always_comb begin
        for (int w = 0; w < dcache_pkg::DC_WAYS; w++) begin
            way_hit[w] = valids[w] && (tags[w] == req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    assign miss    = rq.valid && !hit;

    // invalid way first, otherwise the lru way
    assign victim_way = !valids[0] ? 1'b0 : (!valids[1] ? 1'b1 : lru);

    assign sel_line = lines[hit_way];

    // write hit: merge one word into the hit line
    always_comb begin
        hit_line            = sel_line;
        hit_line.words[off] = rq.wdata;
    end

    assign hit_we = rq.valid && rq.we && hit;

    ////////////////////
    // response register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= rq.valid && hit;  // reads and writes alike
        end
    end

    always_ff @(posedge clk) begin
        if (rq.valid && hit && !rq.we) begin
            rdata <= sel_line.words[off];
        end
    end

    // a fill only ever targets a way that missed
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!rst_n) rq.valid |-> !(&way_hit)
    );

endmodule

`default_nettype wire

/* src/dcache_miss_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_miss_ctrl #(
    parameter  int NUM_SETS = 16,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = dcache_pkg::DC_LINE_ADDR_W - IDX_W
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    dcache_req_if.dst                                      rq,
    input  logic                                           miss,
    input  logic                                           victim_way,
    input  logic [dcache_pkg::DC_WAYS-1:0][TAG_W-1:0]      tags,
    input  logic [dcache_pkg::DC_WAYS-1:0]                 valids,
    input  logic [dcache_pkg::DC_WAYS-1:0]                 dirties,
    input  dcache_pkg::dc_line_u [dcache_pkg::DC_WAYS-1:0] lines,
    input  logic                                           mem_done,
    input  dcache_pkg::dc_line_u                           mem_rdata,
    output logic                                           hold,
    output logic                                           fill_we,
    output logic                                           fill_way,
    output dcache_pkg::dc_line_u                           fill_line,
    output logic [TAG_W-1:0]                               fill_tag,
    output logic                                           mem_req,
    output logic                                           mem_we,
    output logic [dcache_pkg::DC_LINE_ADDR_W-1:0]          mem_addr,
    output dcache_pkg::dc_line_u                           mem_wdata
);

    localparam logic [1:0] ST_IDLE        = 2'd0;
    localparam logic [1:0] ST_WB_WAIT     = 2'd1;  // victim write-back in flight
    localparam logic [1:0] ST_REFILL_WAIT = 2'd2;
    localparam logic [1:0] ST_FILL        = 2'd3;

    logic [1:0]                          state;
    logic                                victim_dirty;
    logic [dcache_pkg::DC_LINE_ADDR_W-1:0] req_line;
    logic [IDX_W-1:0]                    idx;

    assign req_line     = rq.addr[dcache_pkg::DC_ADDR_W-1 -: dcache_pkg::DC_LINE_ADDR_W];
    assign idx          = req_line[IDX_W-1:0];
    assign victim_dirty = valids[victim_way] && dirties[victim_way];

    // stall starts in the very cycle the miss shows up
    assign hold     = (state != ST_IDLE) || miss;
    assign fill_we  = (state == ST_FILL);
    assign fill_tag = req_line[dcache_pkg::DC_LINE_ADDR_W-1 -: TAG_W];

    ////////////////////
    // fsm
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            mem_req <= 1'b0;  // single-cycle strobe
            case (state)
                ST_IDLE: begin
                    if (miss) begin
                        mem_req <= 1'b1;
                        if (victim_dirty) begin
                            mem_we <= 1'b1;
                            state  <= ST_WB_WAIT;
                        end else begin
                            mem_we <= 1'b0;
                            state  <= ST_REFILL_WAIT;
                        end
                    end
                end
                ST_WB_WAIT: begin
                    if (mem_done) begin
                        mem_req <= 1'b1;  // now the refill read
                        mem_we  <= 1'b0;
                        state   <= ST_REFILL_WAIT;
                    end
                end
                ST_REFILL_WAIT: begin
                    if (mem_done) begin
                        state <= ST_FILL;
                    end
                end
                default: begin
                    state <= ST_IDLE;  // fill done, replay follows
                end
            endcase
        end
    end

    ////////////////////
    // miss payload
    ////////////////////

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (miss) begin
                    fill_way  <= victim_way;
                    mem_wdata <= lines[victim_way];
                    // dirty victim goes back to its own line address
                    mem_addr  <= victim_dirty ? {tags[victim_way], idx} : req_line;
                end
            end
            ST_WB_WAIT: begin
                if (mem_done) begin
                    mem_addr <= req_line;
                end
            end
            ST_REFILL_WAIT: begin
                if (mem_done) begin
                    fill_line <= mem_rdata;
                end
            end
            default: begin
            end
        endcase
    end

    a_done_only_when_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_done |-> (state == ST_WB_WAIT || state == ST_REFILL_WAIT)
    );

endmodule

`default_nettype wire

/* src/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
    parameter int NUM_SETS = 16
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // cpu port
    input  logic                                  req,
    input  logic                                  we,
    input  logic [dcache_pkg::DC_ADDR_W-1:0]      addr,
    input  logic [dcache_pkg::DC_WORD_W-1:0]      wdata,
    output logic                                  ready,
    output logic                                  resp_valid,
    output logic [dcache_pkg::DC_WORD_W-1:0]      rdata,
    // next-level memory port
    output logic                                  mem_req,
    output logic                                  mem_we,
    output logic [dcache_pkg::DC_LINE_ADDR_W-1:0] mem_addr,
    output dcache_pkg::dc_line_u                  mem_wdata,
    input  logic                                  mem_done,
    input  dcache_pkg::dc_line_u                  mem_rdata
);

    localparam int TAG_W = dcache_pkg::DC_LINE_ADDR_W - $clog2(NUM_SETS);

    logic                                           hold;
    logic                                           hit_we;
    logic                                           hit_way;
    dcache_pkg::dc_line_u                           hit_line;
    logic                                           miss;
    logic                                           victim_way;
    logic                                           fill_we;
    logic                                           fill_way;
    dcache_pkg::dc_line_u                           fill_line;
    logic [TAG_W-1:0]                               fill_tag;
    logic [dcache_pkg::DC_WAYS-1:0][TAG_W-1:0]      tags;
    logic [dcache_pkg::DC_WAYS-1:0]                 valids;
    logic [dcache_pkg::DC_WAYS-1:0]                 dirties;
    logic                                           lru;
    dcache_pkg::dc_line_u [dcache_pkg::DC_WAYS-1:0] lines;

    dcache_req_if rq_if ();

    dcache_lookup #(.NUM_SETS(NUM_SETS)) u_lookup (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .ready     (ready),
        .hold      (hold),
        .hit_we    (hit_we),
        .hit_way   (hit_way),
        .hit_line  (hit_line),
        .fill_we   (fill_we),
        .fill_way  (fill_way),
        .fill_line (fill_line),
        .fill_tag  (fill_tag),
        .rq        (rq_if.src),
        .tags      (tags),
        .valids    (valids),
        .dirties   (dirties),
        .lru       (lru),
        .lines     (lines)
    );

    dcache_hit_check #(.NUM_SETS(NUM_SETS)) u_hit_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .rq         (rq_if.dst),
        .tags       (tags),
        .valids     (valids),
        .lru        (lru),
        .lines      (lines),
        .hit_we     (hit_we),
        .hit_way    (hit_way),
        .hit_line   (hit_line),
        .miss       (miss),
        .victim_way (victim_way),
        .resp_valid (resp_valid),
        .rdata      (rdata)
    );

    dcache_miss_ctrl #(.NUM_SETS(NUM_SETS)) u_miss_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .rq         (rq_if.dst),
        .miss       (miss),
        .victim_way (victim_way),
        .tags       (tags),
        .valids     (valids),
        .dirties    (dirties),
        .lines      (lines),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata),
        .hold       (hold),
        .fill_we    (fill_we),
        .fill_way   (fill_way),
        .fill_line  (fill_line),
        .fill_tag   (fill_tag),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

endmodule

`default_nettype wire

/* bench/dcache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int N_DIRECTED  = 24;
    localparam int N_RANDOM    = 400;
    localparam int MISS_WORST  = 20;   // cycles for a dirty write-back plus refill
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * MISS_WORST + 200;
    localparam int DRAIN_LIMIT = 100;
    localparam logic [31:0] RAND_BASE = 32'h0010_0000;

    logic                        clk;
    logic                        rst_n;
    logic                        req;
    logic                        we;
    logic [31:0]                 addr;
    logic [31:0]                 wdata;
    logic                        ready;
    logic                        resp_valid;
    logic [31:0]                 rdata;
    logic                        mem_req;
    logic                        mem_we;
    logic [27:0]                 mem_addr;
    dcache_pkg::dc_line_u        mem_wdata;
    logic                        mem_done;
    dcache_pkg::dc_line_u        mem_rdata;

    integer      seed = 6;
    int          cyc = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          req_count = 0;
    int          resp_count = 0;
    string       test_name = "reset";

    // expected responses in request order
    logic [31:0] exp_q[$];
    bit          wr_q[$];
    bit          lat_q[$];
    int          cyc_q[$];
    string       name_q[$];

    logic [31:0]  shadow  [logic [29:0]];   // every word written so far
    logic [127:0] backing [logic [27:0]];   // lines the cache wrote back

    // memory model state
    bit           mem_busy = 1'b0;
    int           mem_wait;
    bit           pend_we;
    logic [27:0]  pend_addr;
    logic [127:0] pend_line;
    int           wb_count = 0;
    logic [27:0]  last_wb_addr = '0;

    dcache_top #(.NUM_SETS(16)) dcache_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .ready      (ready),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////
    // reference model
    ////////////////////

    // pattern of untouched memory mixes every address bit
    function automatic logic [31:0] pattern_word(input logic [29:0] waddr);
        return ({2'b00, waddr} * 32'h9E37_79B1) ^ 32'h3C5A_A5C3;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        if (shadow.exists(a[31:2])) begin
            return shadow[a[31:2]];
        end
        return pattern_word(a[31:2]);
    endfunction

    function automatic logic [127:0] read_line(input logic [27:0] la);
        logic [127:0] l;
        if (backing.exists(la)) begin
            return backing[la];
        end
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = pattern_word({la, 2'(i)});
        end
        return l;
    endfunction

    ////////////////////
    // cpu side
    ////////////////////

    // called on a falling edge and returns on the next one
    task automatic cpu_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                              input logic chk_lat);
        if (chk_lat) begin
            assert (ready) else begin
                $display("%s: ready was low in front of a read that should hit", test_name);
                protocol_errors++;
            end
        end
        while (!ready) begin
            req = 1'b0;
            @(negedge clk);
        end
        req   = 1'b1;
        we    = wr;
        addr  = a;
        wdata = d;
        if (wr) begin
            shadow[a[31:2]] = d;
            exp_q.push_back(32'h0);
        end else begin
            exp_q.push_back(ref_read(a));
        end
        wr_q.push_back(wr);
        lat_q.push_back(chk_lat);
        cyc_q.push_back(cyc);
        name_q.push_back(test_name);
        req_count++;
        @(negedge clk);
        req = 1'b0;
        we  = 1'b0;
        if (wr) begin
            assert (!ready) else begin
                $display("%s: ready stayed high in the cycle after a write was accepted",
                         test_name);
                protocol_errors++;
            end
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d requests still without a response after %0d cycles",
                     test_name, exp_q.size(), DRAIN_LIMIT);
            protocol_errors++;
        end
    endtask

    always @(negedge clk) begin : compare_resp
        logic [31:0] exp_v;
        bit          was_wr;
        bit          lat_on;
        int          c0;
        string       nm;
        if (rst_n && resp_valid) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                $display("response arrived with no request outstanding");
                protocol_errors++;
            end else begin
                exp_v  = exp_q.pop_front();
                was_wr = wr_q.pop_front();
                lat_on = lat_q.pop_front();
                c0     = cyc_q.pop_front();
                nm     = name_q.pop_front();
                if (!was_wr) begin
                    assert (rdata === exp_v) else begin
                        $display("Error: %s read expected %h actual %h", nm, exp_v, rdata);
                        value_errors++;
                    end
                end
                if (lat_on) begin
                    assert (cyc - c0 == 2) else begin
                        $display("Error: %s hit latency expected 2 actual %0d", nm, cyc - c0);
                        value_errors++;
                    end
                end
            end
        end
    end

    ////////////////////
    // memory model
    ////////////////////

    always @(negedge clk) begin : mem_model
        logic [31:0] exp_w;
        mem_done = 1'b0;
        if (!rst_n) begin
            mem_busy = 1'b0;
        end else begin
            if (mem_busy) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    mem_busy = 1'b0;
                    if (pend_we) begin
                        backing[pend_addr] = pend_line;
                    end else begin
                        mem_rdata.flat = read_line(pend_addr);
                    end
                    mem_done = 1'b1;
                end
            end
            if (mem_req) begin
                if (mem_busy) begin
                    $display("memory request issued before the previous one completed");
                    protocol_errors++;
                end
                if (mem_we) begin  // victim must match what the cpu wrote
                    for (int i = 0; i < 4; i++) begin
                        exp_w = ref_read({mem_addr, 2'(i), 2'b00});
                        assert (mem_wdata.words[i] === exp_w) else begin
                            $display("Error: %s write-back word %0d expected %h actual %h",
                                     test_name, i, exp_w, mem_wdata.words[i]);
                            value_errors++;
                        end
                    end
                    wb_count++;
                    last_wb_addr = mem_addr;
                end
                pend_we   = mem_we;
                pend_addr = mem_addr;
                pend_line = mem_wdata.flat;
                mem_busy  = 1'b1;
                mem_wait  = 1 + ($unsigned($random(seed)) % 4);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles in test %s, the run did not finish",
                 WATCHDOG_CYCLES, test_name);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////
    // tests
    ////////////////////

    initial begin : main
        logic [31:0] a;
        logic [31:0] d;
        int          wb_before;
        rst_n     = 1'b0;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        mem_done  = 1'b0;
        mem_rdata = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        assert (ready) else begin
            $display("ready is low right after reset");
            protocol_errors++;
        end

        test_name = "cold_read";  // clean miss, refill, replay
        cpu_access(1'b0, 32'h0000_1004, '0, 1'b0);
        drain();

        test_name = "read_hit";
        cpu_access(1'b0, 32'h0000_1000, '0, 1'b1);
        cpu_access(1'b0, 32'h0000_1008, '0, 1'b1);
        cpu_access(1'b0, 32'h0000_100C, '0, 1'b1);
        cpu_access(1'b0, 32'h0000_1004, '0, 1'b1);
        drain();
        cpu_access(1'b0, 32'h0000_2000, '0, 1'b0);  // second way of set 0
        drain();
        cpu_access(1'b0, 32'h0000_1000, '0, 1'b1);
        cpu_access(1'b0, 32'h0000_2004, '0, 1'b1);
        cpu_access(1'b0, 32'h0000_1008, '0, 1'b1);
        cpu_access(1'b0, 32'h0000_200C, '0, 1'b1);
        drain();

        test_name = "write_then_read";
        d = $random(seed);
        cpu_access(1'b1, 32'h0000_3024, d, 1'b0);
        cpu_access(1'b0, 32'h0000_3024, '0, 1'b0);
        cpu_access(1'b0, 32'h0000_3020, '0, 1'b0);
        cpu_access(1'b0, 32'h0000_3028, '0, 1'b0);
        drain();

        // three lines in set 5 so the written one gets evicted
        test_name = "eviction";
        d = $random(seed);
        cpu_access(1'b1, 32'h0004_0054, d, 1'b0);
        cpu_access(1'b0, 32'h0005_0050, '0, 1'b0);
        drain();
        wb_before = wb_count;
        cpu_access(1'b0, 32'h0006_0058, '0, 1'b0);
        drain();
        assert (wb_count == wb_before + 1) else begin
            $display("Error: %s write-backs expected %0d actual %0d",
                     test_name, wb_before + 1, wb_count);
            value_errors++;
        end
        assert (last_wb_addr == 28'h0004_005) else begin
            $display("Error: %s write-back address expected %h actual %h",
                     test_name, 28'h0004_005, last_wb_addr);
            value_errors++;
        end
        cpu_access(1'b0, 32'h0004_0054, '0, 1'b0);
        cpu_access(1'b0, 32'h0004_0050, '0, 1'b0);
        drain();

        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++) begin
            a = RAND_BASE | (32'($random(seed)) & 32'h0000_03FC);  // 4 lines per set
            d = $random(seed);
            cpu_access(1'($random(seed)), a, d, 1'b0);
        end
        drain();

        repeat (4) @(negedge clk);
        assert (resp_count == req_count) else begin
            $display("%0d requests were issued but %0d responses came back",
                     req_count, resp_count);
            protocol_errors++;
        end
        $display("requests: %0d, value errors: %0d, protocol errors: %0d",
                 req_count, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/dcache_pkg.sv
src/dcache_req_if.sv
src/dcache_lookup.sv
src/dcache_hit_check.sv
src/dcache_miss_ctrl.sv
src/dcache_top.sv
bench/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - src/dcache_pkg.sv
      - src/dcache_req_if.sv
      - src/dcache_lookup.sv
      - src/dcache_hit_check.sv
      - src/dcache_miss_ctrl.sv
      - src/dcache_top.sv
  - target: simulation
    files:
      - bench/dcache_tb.sv
